//--- rv_core.f
+incdir+common
+incdir+sim
common/rv_isa_pkg.sv
common/rv_bus_pkg.sv
hdl/rv_regfile.sv
hdl/rv_mem_arbiter.sv
core/rv_fetch.sv
core/rv_exec.sv
core/rv_lsu.sv
hdl/rv_core.sv
sim/tb_rv_core.sv

//--- sim/tb_rv_tests.svh
`ifndef TB_RV_TESTS_SVH
`define TB_RV_TESTS_SVH

task automatic arithmetic_ops();
  word_t a;
  word_t b;
  word_t exp [6];
  a = 32'h1234_5678;
  b = -32'd5;
  new_program();
  prog.push_back(utype(op_lui, 1, 32'h80001));
  prog.push_back(utype(op_lui, 2, 32'h12345));
  prog.push_back(itype(op_imm, 3'b000, 2, 2, 32'h678));
  prog.push_back(itype(op_imm, 3'b000, 3, 0, -32'd5));
  prog.push_back(rtype(7'h00, 4, 2, 3));
  prog.push_back(rtype(7'h20, 5, 2, 3));
  prog.push_back(rtype(7'h20, 6, 3, 2));
  prog.push_back(utype(op_auipc, 7, 32'h00010));  // sits at offset 0x1c
  for (int i = 0; i < 6; i++) begin
    prog.push_back(stype(f3_sw, 1, reg_addr_t'(i + 2), 4 * i));
  end
  prog.push_back(ebreak_word);
  exp = '{a, b, a + b, a - b, b - a, `RV_RESET_PC + 32'h1c + 32'h0001_0000};
  run_program();
  check_word("write count", wr_log.size(), 6);
  for (int i = 0; i < 6; i++) begin
    expect_write(i, result_base + 4 * i, exp[i], 4'hF);
  end
endtask

// one load from x2 + off, then its result stored to the next result slot
task automatic add_load(funct3_t f3, int off, word_t value);
  prog.push_back(itype(op_load, f3, 3, 2, off));
  prog.push_back(stype(f3_sw, 1, 3, 4 * expected.size()));
  expected.push_back(value);
endtask

task automatic load_extension();
  word_t       data;
  logic [7:0]  bt;
  logic [15:0] hw;
  data = 32'hC302_7F81;  // mixed sign bits in bytes and halves
  new_program();
  mem_array[32'h8000_2000] = data;
  prog.push_back(utype(op_lui, 1, 32'h80001));
  prog.push_back(utype(op_lui, 2, 32'h80002));
  for (int off = 0; off < 4; off++) begin
    bt = data[8*off +: 8];
    add_load(f3_lb, off, {{24{bt[7]}}, bt});
    add_load(f3_lbu, off, {24'h00_0000, bt});
  end
  for (int off = 0; off < 4; off += 2) begin
    hw = data[8*off +: 16];
    add_load(f3_lh, off, {{16{hw[15]}}, hw});
    add_load(f3_lhu, off, {16'h0000, hw});
  end
  add_load(f3_lw, 0, data);
  prog.push_back(ebreak_word);
  run_program();
  check_word("write count", wr_log.size(), expected.size());
  foreach (expected[i]) begin
    expect_write(i, result_base + 4 * i, expected[i], 4'hF);
  end
endtask

task automatic store_lanes();
  word_t vals [4];
  vals = '{32'h7A1, 32'h6B2, 32'h5C3, 32'h4D4};  // upper bits must not leak
  new_program();
  mem_array[32'h8000_3000] = 32'h1122_3344;
  mem_array[32'h8000_3004] = 32'h5566_7788;
  mem_array[32'h8000_3008] = 32'h99AA_BBCC;
  prog.push_back(utype(op_lui, 1, 32'h80001));
  prog.push_back(utype(op_lui, 7, 32'h80003));
  for (int i = 0; i < 4; i++) begin
    prog.push_back(itype(op_imm, 3'b000, reg_addr_t'(i + 2), 0, vals[i]));
  end
  prog.push_back(itype(op_imm, 3'b000, 6, 0, -32'd1488));  // x6 = 0xfffffa30
  for (int i = 0; i < 4; i++) begin
    prog.push_back(stype(f3_sb, 7, reg_addr_t'(i + 2), i));
  end
  prog.push_back(stype(f3_sh, 7, 6, 6));
  prog.push_back(stype(f3_sh, 7, 6, 8));
  for (int i = 0; i < 3; i++) begin
    prog.push_back(itype(op_load, f3_lw, 8, 7, 4 * i));
    prog.push_back(stype(f3_sw, 1, 8, 4 * i));
  end
  prog.push_back(ebreak_word);
  run_program();
  check_word("write count", wr_log.size(), 9);
  for (int i = 0; i < 4; i++) begin
    expect_write(i, 32'h8000_3000, vals[i] << (8 * i), 4'b0001 << i);
  end
  expect_write(4, 32'h8000_3004, 32'hFFFF_FA30 << 16, 4'b1100);
  expect_write(5, 32'h8000_3008, 32'hFFFF_FA30, 4'b0011);
  expect_write(6, result_base, 32'hD4C3_B2A1, 4'hF);
  expect_write(7, result_base + 4, 32'hFA30_7788, 4'hF);
  expect_write(8, result_base + 8, 32'h99AA_FA30, 4'hF);
endtask

// taken path stores at 8*c, fall-through path at 8*c + 4
task automatic add_branch_case(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2, bit taken);
  int unsigned c;
  c = expected.size();
  prog.push_back(btype(f3, rs1, rs2, 12));
  prog.push_back(stype(f3_sw, 1, 0, 8 * c + 4));
  prog.push_back(jtype(0, 8));
  prog.push_back(stype(f3_sw, 1, 0, 8 * c));
  expected.push_back(taken ? result_base + 8 * c : result_base + 8 * c + 4);
endtask

task automatic branch_decisions();
  new_program();
  prog.push_back(utype(op_lui, 1, 32'h80001));
  prog.push_back(itype(op_imm, 3'b000, 2, 0, -32'd1));  // x2 = -1, huge unsigned
  prog.push_back(itype(op_imm, 3'b000, 3, 0, 1));
  prog.push_back(itype(op_imm, 3'b000, 4, 0, 1));
  add_branch_case(f3_beq, 3, 4, 1'b1);
  add_branch_case(f3_beq, 2, 3, 1'b0);
  add_branch_case(f3_bne, 2, 3, 1'b1);
  add_branch_case(f3_bne, 3, 4, 1'b0);
  add_branch_case(f3_blt, 2, 3, 1'b1);
  add_branch_case(f3_blt, 3, 2, 1'b0);
  add_branch_case(f3_bge, 3, 2, 1'b1);
  add_branch_case(f3_bge, 2, 3, 1'b0);
  add_branch_case(f3_bltu, 3, 2, 1'b1);
  add_branch_case(f3_bltu, 2, 3, 1'b0);
  add_branch_case(f3_bgeu, 2, 3, 1'b1);
  add_branch_case(f3_bgeu, 3, 2, 1'b0);
  prog.push_back(ebreak_word);
  run_program();
  check_word("write count", wr_log.size(), expected.size());
  foreach (expected[i]) begin
    expect_write(i, expected[i], '0, 4'hF);
  end
endtask

task automatic jump_links();
  new_program();
  prog.push_back(utype(op_lui, 1, 32'h80001));
  prog.push_back(jtype(5, 12));                       // 0x04 -> 0x10
  prog.push_back(stype(f3_sw, 1, 0, 32'h40));
  prog.push_back(stype(f3_sw, 1, 0, 32'h40));
  prog.push_back(stype(f3_sw, 1, 5, 0));
  prog.push_back(utype(op_auipc, 6, 0));              // x6 = base + 0x14
  prog.push_back(itype(op_imm, 3'b000, 6, 6, 32'h1B)); // odd base
  prog.push_back(itype(op_jalr, 3'b000, 7, 6, 2));    // 0x1c -> 0x30
  for (int i = 0; i < 4; i++) begin
    prog.push_back(stype(f3_sw, 1, 0, 32'h44));
  end
  prog.push_back(stype(f3_sw, 1, 7, 4));
  prog.push_back(ebreak_word);
  run_program();
  check_word("write count", wr_log.size(), 2);
  expect_write(0, result_base, `RV_RESET_PC + 32'h04 + 32'd4, 4'hF);
  expect_write(1, result_base + 4, `RV_RESET_PC + 32'h1C + 32'd4, 4'hF);
endtask

task automatic halt_behavior();
  new_program();
  prog.push_back(utype(op_lui, 1, 32'h80001));
  prog.push_back(itype(op_imm, 3'b000, 2, 0, 32'h55));
  prog.push_back(stype(f3_sw, 1, 2, 0));
  prog.push_back(ebreak_word);
  run_program();
  repeat (20) begin
    @(negedge clk);
    check_flag("mem_req", mem_req, 1'b0);
    check_flag("halted", halted, 1'b1);
    check_word("pc", pc, `RV_RESET_PC + 32'h0C);
  end
  check_word("write count", wr_log.size(), 1);
  expect_write(0, result_base, 32'h55, 4'hF);
endtask

`endif

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module tb_rv_core import rv_isa_pkg::*, rv_bus_pkg::*; ();

  localparam word_t result_base = 32'h8000_1000;
  localparam word_t ebreak_word = 32'h0010_0073;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     mem_req;
  mem_req_t mem;
  logic     mem_ack = 1'b0;
  word_t    mem_rdata = '0;
  word_t    pc;
  logic     halted;

  word_t       mem_array [word_t];
  mem_req_t    wr_log [$];     // every write the memory accepted
  word_t       prog [$];
  word_t       expected [$];
  integer      seed = 87665;
  logic [1:0]  wait_left;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 100;

  always #5 clk = ~clk;

  rv_core dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem       (mem),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .halted    (halted)
  );

  // unwritten words read as a pattern of their address
  function automatic word_t read_word(word_t addr);
    if (mem_array.exists(addr)) begin
      return mem_array[addr];
    end
    return addr ^ 32'h5A5A_A5A5;
  endfunction

  function automatic word_t lane_bits(wmask_t mask);
    word_t bits;
    for (int i = 0; i < 4; i++) begin
      bits[8*i +: 8] = {8{mask[i]}};
    end
    return bits;
  endfunction

  // four-phase slave, 0 to 3 cycles before each ack
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack   <= 1'b0;
      wait_left <= 2'($random(seed));
    end else if (mem_ack) begin
      if (!mem_req) begin
        mem_ack <= 1'b0;
      end
    end else if (mem_req && (wait_left != 2'd0)) begin
      wait_left <= wait_left - 2'd1;
    end else if (mem_req) begin
      mem_rdata <= read_word(mem.addr);
      if (mem.we) begin
        mem_array[mem.addr] = (read_word(mem.addr) & ~lane_bits(mem.wmask)) |
                              (mem.wdata & lane_bits(mem.wmask));
        wr_log.push_back(mem);
      end
      mem_ack   <= 1'b1;
      wait_left <= 2'($random(seed));
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the core did not reach ebreak within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_mask(string name, wmask_t got, wmask_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // only the lanes in the mask are compared for data
  task automatic expect_write(int idx, word_t addr, word_t data, wmask_t mask);
    check_word($sformatf("write %0d addr", idx), wr_log[idx].addr, addr);
    check_mask($sformatf("write %0d wmask", idx), wr_log[idx].wmask, mask);
    check_word($sformatf("write %0d wdata", idx), wr_log[idx].wdata & lane_bits(mask),
               data & lane_bits(mask));
  endtask

  function automatic word_t itype(opcode_e op, funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                  word_t imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t stype(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2, word_t imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t btype(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2, word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t utype(opcode_e op, reg_addr_t rd, word_t imm20);
    return {imm20[19:0], rd, op};
  endfunction

  function automatic word_t jtype(reg_addr_t rd, word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic word_t rtype(logic [6:0] f7, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, op_reg};
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic new_program();
    prog.delete();
    expected.delete();
    mem_array.delete();
  endtask

  // load, reset, run to ebreak, then pc must sit on the ebreak
  task automatic run_program();
    foreach (prog[i]) begin
      mem_array[`RV_RESET_PC + 4 * i] = prog[i];
    end
    cycle_limit += 40 * prog.size() + 40;
    wr_log.delete();
    apply_reset();
    @(negedge clk);
    check_flag("halted", halted, 1'b0);
    check_flag("mem_req", mem_req, 1'b0);
    check_word("pc", pc, `RV_RESET_PC);
    while (!halted) begin
      @(negedge clk);
    end
    check_word("pc", pc, `RV_RESET_PC + 4 * (prog.size() - 1));
  endtask

  `include "tb_rv_tests.svh"

  initial begin
    rst_n = 1'b0;
    arithmetic_ops();
    load_extension();
    store_lanes();
    branch_decisions();
    jump_links();
    halt_behavior();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output logic     mem_req,
  output mem_req_t mem,
  input  logic     mem_ack,
  input  word_t    mem_rdata,
  output word_t    pc,
  output logic     halted
);

  inst_u     inst;
  logic      inst_valid;
  logic      retire;
  word_t     next_pc;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  logic      ls_start;
  ls_req_t   ls;
  logic      ls_done;
  word_t     load_data;
  // fetch side of the arbiter
  logic      if_req;
  word_t     if_addr;
  logic      if_ack;
  word_t     if_rdata;
  // lsu side of the arbiter
  logic      ls_req;
  mem_req_t  ls_mem;
  logic      ls_ack;
  word_t     ls_rdata;

  rv_fetch fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .retire     (retire),
    .next_pc    (next_pc),
    .pc         (pc),
    .inst       (inst),
    .inst_valid (inst_valid),
    .if_req     (if_req),
    .if_addr    (if_addr),
    .if_ack     (if_ack),
    .if_rdata   (if_rdata)
  );

  rv_exec exec_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .pc         (pc),
    .inst_valid (inst_valid),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .ls_start   (ls_start),
    .ls         (ls),
    .ls_done    (ls_done),
    .load_data  (load_data),
    .retire     (retire),
    .next_pc    (next_pc),
    .halted     (halted)
  );

  rv_lsu lsu_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ls_start  (ls_start),
    .ls        (ls),
    .ls_done   (ls_done),
    .load_data (load_data),
    .ls_req    (ls_req),
    .ls_mem    (ls_mem),
    .ls_ack    (ls_ack),
    .ls_rdata  (ls_rdata)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  rv_mem_arbiter arbiter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .if_req    (if_req),
    .if_addr   (if_addr),
    .if_ack    (if_ack),
    .if_rdata  (if_rdata),
    .ls_req    (ls_req),
    .ls_mem    (ls_mem),
    .ls_ack    (ls_ack),
    .ls_rdata  (ls_rdata),
    .mem_req   (mem_req),
    .mem       (mem),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- core/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ls_start,
  input  ls_req_t  ls,
  output logic     ls_done,
  output word_t    load_data,
  output logic     ls_req,
  output mem_req_t ls_mem,
  input  logic     ls_ack,
  input  word_t    ls_rdata
);

  typedef enum logic [1:0] {st_idle, st_req, st_wait, st_done} lsu_state_e;

  lsu_state_e state;
  logic [1:0] offs;       // byte offset within the word
  word_t      lane_data;  // addressed lane moved down to bit 0
  word_t      load_ext;
  wmask_t     st_mask;

  assign offs      = ls.addr[1:0];
  assign lane_data = ls_rdata >> {offs, 3'b000};

  always_comb begin
    case (ls.funct3)
      f3_lb:   load_ext = {{24{lane_data[7]}}, lane_data[7:0]};
      f3_lh:   load_ext = {{16{lane_data[15]}}, lane_data[15:0]};
      f3_lw:   load_ext = lane_data;
      f3_lbu:  load_ext = {24'h00_0000, lane_data[7:0]};
      f3_lhu:  load_ext = {16'h0000, lane_data[15:0]};
      default: load_ext = '0;
    endcase
  end

  // misaligned halfword or word gives an empty mask
  always_comb begin
    case (ls.funct3)
      f3_sb:   st_mask = 4'b0001 << offs;
      f3_sh:   st_mask = offs[0] ? 4'b0000 : (4'b0011 << offs);
      f3_sw:   st_mask = (offs == 2'b00) ? 4'b1111 : 4'b0000;
      default: st_mask = 4'b0000;
    endcase
  end

  assign ls_mem = '{we:    ls.store,
                    addr:  {ls.addr[31:2], 2'b00},
                    wdata: ls.wdata << {offs, 3'b000},
                    wmask: ls.store ? st_mask : 4'b1111};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (ls_start && !ls_ack) begin
            state <= st_req;
          end
        end
        st_req: begin
          if (ls_ack) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (!ls_ack) begin
            state <= st_done;
          end
        end
        default: state <= st_idle;  // st_done lasts one cycle
      endcase
    end
  end

  // only loads bring data back
  always_ff @(posedge clk) begin
    if ((state == st_req) && ls_ack && ls.load) begin
      load_data <= load_ext;
    end
  end

  assign ls_req  = (state == st_req);
  assign ls_done = (state == st_done);

endmodule

//--- core/rv_exec.sv
`timescale 1ns/1ps

module rv_exec import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  inst_u     inst,
  input  word_t     pc,
  input  logic      inst_valid,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output logic      rf_we,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata,
  output logic      ls_start,
  output ls_req_t   ls,
  input  logic      ls_done,
  input  word_t     load_data,
  output logic      retire,
  output word_t     next_pc,
  output logic      halted
);

  logic  is_lui;
  logic  is_auipc;
  logic  is_jal;
  logic  is_jalr;
  logic  is_branch;
  logic  is_load;
  logic  is_store;
  logic  is_imm;
  logic  is_reg;
  logic  is_ebreak;
  logic  is_mem;
  logic  writes_rd;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t op_a;
  word_t op_b;
  logic  sub;
  word_t sum;
  word_t pc_plus4;
  logic  taken;

  assign is_lui    = (inst.u.opcode == op_lui);
  assign is_auipc  = (inst.u.opcode == op_auipc);
  assign is_jal    = (inst.j.opcode == op_jal);
  assign is_jalr   = (inst.i.opcode == op_jalr);
  assign is_branch = (inst.b.opcode == op_branch);
  assign is_load   = (inst.i.opcode == op_load);
  assign is_store  = (inst.s.opcode == op_store);
  assign is_imm    = (inst.i.opcode == op_imm);
  assign is_reg    = (inst.r.opcode == op_reg);
  assign is_ebreak = (inst.i.opcode == op_system) && (inst.i.imm == 12'h001);
  assign is_mem    = is_load || is_store;
  assign writes_rd = is_lui || is_auipc || is_jal || is_jalr || is_load || is_imm || is_reg;

  // immediates, sign taken from inst[31]
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
  assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                  inst.b.imm4_1, 1'b0};
  assign imm_u = {inst.u.imm31_12, 12'h000};
  assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                  inst.j.imm10_1, 1'b0};

  // operand choice for the single adder
  always_comb begin
    op_a = rs1_data;
    op_b = imm_i;  // addi, load, jalr
    if (is_lui) begin
      op_a = '0;
      op_b = imm_u;
    end else if (is_auipc) begin
      op_a = pc;
      op_b = imm_u;
    end else if (is_jal) begin
      op_a = pc;
      op_b = imm_j;
    end else if (is_branch) begin
      op_a = pc;  // target only, compare is separate
      op_b = imm_b;
    end else if (is_store) begin
      op_b = imm_s;
    end else if (is_reg) begin
      op_b = rs2_data;
    end
  end

  assign sub      = is_reg && inst.r.funct7[5];
  assign sum      = op_a + (op_b ^ {$bits(word_t){sub}}) + word_t'(sub);
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (inst.b.funct3)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: taken = (rs1_data < rs2_data);
      f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jal || (is_branch && taken)) begin
      next_pc = sum;
    end else if (is_jalr) begin
      next_pc = {sum[31:1], 1'b0};  // low bit dropped
    end else begin
      next_pc = pc_plus4;
    end
  end

  // memory ops end on ls_done, ebreak never ends
  assign retire   = is_mem ? ls_done : (inst_valid && !is_ebreak);
  assign ls_start = inst_valid && is_mem && !ls_done;
  assign ls       = '{load: is_load, store: is_store, funct3: inst.i.funct3,
                      addr: sum, wdata: rs2_data};

  assign rs1_addr = inst.r.rs1;
  assign rs2_addr = inst.r.rs2;
  assign rf_we    = retire && writes_rd;
  assign rf_waddr = inst.r.rd;
  assign rf_wdata = is_load              ? load_data :
                    (is_jal || is_jalr)  ? pc_plus4  : sum;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (inst_valid && is_ebreak) begin
      halted <= 1'b1;  // sticky until reset
    end
  end

endmodule

//--- core/rv_fetch.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_fetch import rv_isa_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  retire,
  input  word_t next_pc,
  output word_t pc,
  output inst_u inst,
  output logic  inst_valid,
  output logic  if_req,
  output word_t if_addr,
  input  logic  if_ack,
  input  word_t if_rdata
);

  typedef enum logic [1:0] {st_req, st_wait, st_hold} fetch_state_e;

  fetch_state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= st_req;
      if_req <= 1'b0;
      pc     <= `RV_RESET_PC;
    end else begin
      case (state)
        st_req: begin
          if (!if_req && !if_ack) begin
            if_req <= 1'b1;
          end else if (if_req && if_ack) begin
            if_req <= 1'b0;
            state  <= st_wait;
          end
        end
        st_wait: begin
          if (!if_ack) begin
            state <= st_hold;  // handshake closed
          end
        end
        st_hold: begin
          if (retire) begin
            pc    <= next_pc;
            state <= st_req;
          end
        end
        default: state <= st_req;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if ((state == st_req) && if_req && if_ack) begin
      inst <= if_rdata;
    end
  end

  assign inst_valid = (state == st_hold);
  assign if_addr    = pc;

endmodule

//--- hdl/rv_mem_arbiter.sv
`timescale 1ns/1ps

module rv_mem_arbiter import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     if_req,
  input  word_t    if_addr,
  output logic     if_ack,
  output word_t    if_rdata,
  input  logic     ls_req,
  input  mem_req_t ls_mem,
  output logic     ls_ack,
  output word_t    ls_rdata,
  output logic     mem_req,
  output mem_req_t mem,
  input  logic     mem_ack,
  input  word_t    mem_rdata
);

  typedef enum logic [1:0] {own_none, own_if, own_ls} owner_e;

  owner_e   owner;   // grant lock
  owner_e   sel;     // effective grant this cycle
  mem_req_t if_mem;

  // lsu wins when nobody holds the port
  always_comb begin
    if (owner != own_none) begin
      sel = owner;
    end else if (ls_req) begin
      sel = own_ls;
    end else if (if_req) begin
      sel = own_if;
    end else begin
      sel = own_none;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner <= own_none;
    end else if (owner == own_none) begin
      owner <= sel;
    end else if (!mem_req && !mem_ack) begin  // handshake fully closed
      owner <= own_none;
    end
  end

  // instruction reads are whole words
  assign if_mem = '{we: 1'b0, addr: if_addr, wdata: '0, wmask: '1};

  assign mem_req = (sel == own_ls) ? ls_req :
                   (sel == own_if) ? if_req : 1'b0;
  assign mem     = (sel == own_ls) ? ls_mem : if_mem;

  assign if_ack   = (sel == own_if) && mem_ack;
  assign ls_ack   = (sel == own_ls) && mem_ack;
  assign if_rdata = (sel == own_if) ? mem_rdata : '0;
  assign ls_rdata = (sel == own_ls) ? mem_rdata : '0;

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_regfile import rv_isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // x0 stays at its reset value of zero
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

//--- common/rv_bus_pkg.sv
package rv_bus_pkg;

  import rv_isa_pkg::*;

  // one bit per byte lane
  typedef logic [3:0] wmask_t;

  typedef struct packed {
    logic   we;
    word_t  addr;   // word aligned
    word_t  wdata;  // already placed in its lanes
    wmask_t wmask;
  } mem_req_t;

  // execute -> lsu
  typedef struct packed {
    logic    load;
    logic    store;
    funct3_t funct3;
    word_t   addr;   // byte address
    word_t   wdata;  // rs2, unshifted
  } ls_req_t;

endpackage

//--- common/rv_isa_pkg.sv
`include "rv_params.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;
  typedef logic [2:0]            funct3_t;

  typedef enum logic [6:0] {
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_branch = 7'b110_0011,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_imm    = 7'b001_0011,
    op_reg    = 7'b011_0011,
    op_system = 7'b111_0011
  } opcode_e;

  // loads
  localparam funct3_t f3_lb  = 3'b000;
  localparam funct3_t f3_lh  = 3'b001;
  localparam funct3_t f3_lw  = 3'b010;
  localparam funct3_t f3_lbu = 3'b100;
  localparam funct3_t f3_lhu = 3'b101;
  // stores
  localparam funct3_t f3_sb  = 3'b000;
  localparam funct3_t f3_sh  = 3'b001;
  localparam funct3_t f3_sw  = 3'b010;
  // branches
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    funct3_t    funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    funct3_t     funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    funct3_t    funct3;
    logic [4:0] imm4_0;
    opcode_e    opcode;
  } inst_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    funct3_t    funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    reg_addr_t   rd;
    opcode_e     opcode;
  } inst_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_addr_t  rd;
    opcode_e    opcode;
  } inst_j_t;

  // one fetched word, read through whichever format applies
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

endpackage

//--- common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural register count
`define RV_NUM_REGS 32

// index width into the register file
`define RV_REG_AW 5

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

`endif
